/* hw/ntm_scalar_op_pkg.sv */
// Operation codes, result conditions and the command word of the scalar unit
// Shared by the input side, the output side and the testbench

package ntm_scalar_op_pkg;

  ////////////////////////////////////////
  // Operation selection
  ////////////////////////////////////////

  // Scalar operations
  // MUL gives A*B mod M, EXP gives A^B mod M
  typedef enum logic {
    OP_MUL = 1'b0,
    OP_EXP = 1'b1
  } opcode_t;

  ////////////////////////////////////////
  // Result condition
  ////////////////////////////////////////

  // Reported with every READY
  typedef enum logic {
    ERR_NONE         = 1'b0,
    ERR_ZERO_MODULUS = 1'b1
  } error_t;

  ////////////////////////////////////////
  // Command toward the engines
  ////////////////////////////////////////

  // Opcode picks the listening engine
  // Start is a single-cycle pulse
  typedef struct packed {
    opcode_t opcode;
    logic    start;
  } command_t;

endpackage

/* hw/ntm_scalar_ctrl_pkg.sv */
// FSM states of the arithmetic engines and the status word of the output side
// Engines and output side name these by package scope

package ntm_scalar_ctrl_pkg;

  ////////////////////////////////////////
  // Engine FSM states
  ////////////////////////////////////////

  // Bit-serial multiplier
  typedef enum logic [1:0] {
    MULT_IDLE = 2'd0,
    MULT_STEP = 2'd1,
    MULT_DONE = 2'd2
  } mult_state_t;

  // Square-and-multiply exponentiator
  typedef enum logic [1:0] {
    EXP_IDLE     = 2'd0,
    EXP_SQUARE   = 2'd1,
    EXP_MULTIPLY = 2'd2,
    EXP_DONE     = 2'd3
  } exp_state_t;

  ////////////////////////////////////////
  // Output status
  ////////////////////////////////////////

  // Held from one READY to the next
  typedef struct packed {
    logic                      done;
    ntm_scalar_op_pkg::error_t error_code;
  } status_t;

endpackage

/* hw/ntm_scalar_command.sv */
// Input side of the scalar unit, accepts START while idle and latches operands
// Refuses a zero modulus, otherwise dispatches a command pulse to the engines
`timescale 1ns/1ns

module ntm_scalar_command #(
  parameter int DATA_SIZE = 16
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         START,
  input  ntm_scalar_op_pkg::opcode_t   OPCODE,
  input  logic [DATA_SIZE-1:0]         MODULO_IN,
  input  logic [DATA_SIZE-1:0]         DATA_A_IN,
  input  logic [DATA_SIZE-1:0]         DATA_B_IN,
  input  logic                         RESULT_READY,
  output logic                         BUSY,
  output ntm_scalar_op_pkg::command_t  COMMAND,
  output logic                         REFUSE,
  output logic [DATA_SIZE-1:0]         MODULO_OUT,
  output logic [DATA_SIZE-1:0]         DATA_A_OUT,
  output logic [DATA_SIZE-1:0]         DATA_B_OUT
);

  // START counts only while idle
  logic accept;
  // The one place where a zero modulus is detected
  logic modulo_zero;

  assign accept      = START && !BUSY;
  assign modulo_zero = (MODULO_IN == '0);

  // Busy flag and single-cycle pulses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      BUSY    <= 1'b0;
      COMMAND <= '0;
      REFUSE  <= 1'b0;
    end else begin
      COMMAND.start <= 1'b0;
      REFUSE        <= 1'b0;
      if (accept) begin
        BUSY           <= 1'b1;
        COMMAND.opcode <= OPCODE;
        if (modulo_zero) begin
          REFUSE <= 1'b1;
        end else begin
          COMMAND.start <= 1'b1;
        end
      end else if (RESULT_READY) begin
        // Released right after the output side reports
        BUSY <= 1'b0;
      end
    end
  end

  // Operands stay put until the next accepted START
  always_ff @(posedge CLK) begin
    if (accept) begin
      MODULO_OUT <= MODULO_IN;
      DATA_A_OUT <= DATA_A_IN;
      DATA_B_OUT <= DATA_B_IN;
    end
  end

  // A pulse only leaves on the cycle BUSY rises, and never both kinds
  assert property (@(posedge CLK) disable iff (RST)
    (COMMAND.start || REFUSE) |-> ($rose(BUSY) && !(COMMAND.start && REFUSE)));

endmodule

/* hw/ntm_scalar_multiplier.sv */
// Bit-serial interleaved modular multiplier, DATA_OUT = A*B mod M
// START pulse in, READY pulse out DATA_SIZE+2 cycles later, A must be below M
`timescale 1ns/1ns

module ntm_scalar_multiplier #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  ntm_scalar_ctrl_pkg::mult_state_t state;
  logic [CNT_W-1:0]     bit_count;
  // B walked from its MSB
  logic [DATA_SIZE-1:0] b_shift;
  // One spare bit over DATA_SIZE
  logic [DATA_SIZE:0]   acc;
  // 2*acc + A stays below 3*M
  logic [DATA_SIZE+1:0] sum;
  logic [DATA_SIZE+1:0] sum_red1;
  logic [DATA_SIZE+1:0] sum_red2;
  logic [DATA_SIZE+1:0] modulo_ext;

  assign modulo_ext = {2'b00, MODULO_IN};

  ////////////////////////////////////////
  // One step of the interleaved product
  ////////////////////////////////////////

  always_comb begin
    sum      = {acc, 1'b0} + (b_shift[DATA_SIZE-1] ? {2'b00, DATA_A_IN} : '0);
    // Two compare-subtracts bring it back below M
    sum_red1 = (sum >= modulo_ext) ? sum - modulo_ext : sum;
    sum_red2 = (sum_red1 >= modulo_ext) ? sum_red1 - modulo_ext : sum_red1;
  end

  // Control path
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_scalar_ctrl_pkg::MULT_IDLE;
      bit_count <= '0;
      READY     <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        ntm_scalar_ctrl_pkg::MULT_IDLE: begin
          if (START) begin
            bit_count <= CNT_W'(DATA_SIZE - 1);
            state     <= ntm_scalar_ctrl_pkg::MULT_STEP;
          end
        end
        ntm_scalar_ctrl_pkg::MULT_STEP: begin
          bit_count <= bit_count - 1'b1;
          if (bit_count == '0) begin
            state <= ntm_scalar_ctrl_pkg::MULT_DONE;
          end
        end
        ntm_scalar_ctrl_pkg::MULT_DONE: begin
          READY <= 1'b1;
          state <= ntm_scalar_ctrl_pkg::MULT_IDLE;
        end
        default: state <= ntm_scalar_ctrl_pkg::MULT_IDLE;
      endcase
    end
  end

  // Datapath follows the FSM
  always_ff @(posedge CLK) begin
    case (state)
      ntm_scalar_ctrl_pkg::MULT_IDLE: begin
        if (START) begin
          acc     <= '0;
          b_shift <= DATA_B_IN;
        end
      end
      ntm_scalar_ctrl_pkg::MULT_STEP: begin
        acc     <= sum_red2[DATA_SIZE:0];
        b_shift <= b_shift << 1;
      end
      ntm_scalar_ctrl_pkg::MULT_DONE: DATA_OUT <= acc[DATA_SIZE-1:0];
      default: ;
    endcase
  end

  // Reduced accumulator through the whole run
  assert property (@(posedge CLK) disable iff (RST)
    (state != ntm_scalar_ctrl_pkg::MULT_IDLE) |-> (acc < {1'b0, MODULO_IN}));

  // Callers wait for READY before the next START
  assert property (@(posedge CLK) disable iff (RST)
    START |-> (state == ntm_scalar_ctrl_pkg::MULT_IDLE));

endmodule

/* hw/ntm_scalar_exponentiator.sv */
// Left-to-right square-and-multiply exponentiator, DATA_OUT = A^B mod M
// Runs on one private multiplier, latency depends on the top set bit of B
`timescale 1ns/1ns

module ntm_scalar_exponentiator #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  ntm_scalar_ctrl_pkg::exp_state_t state;
  ntm_scalar_ctrl_pkg::exp_state_t next_bit_state;
  logic [CNT_W-1:0]     bit_count;
  // Exponent, current bit at the MSB
  logic [DATA_SIZE-1:0] exponent;
  // Running power, always below M
  logic [DATA_SIZE-1:0] result;
  // Set once the first one bit of B is reached
  logic                 started;
  // Multiplication in flight
  logic                 waiting;
  logic                 mul_start;
  logic                 mul_ready;
  logic [DATA_SIZE-1:0] mul_b;
  logic [DATA_SIZE-1:0] mul_out;

  // Square uses result twice, multiply brings in A
  assign mul_b = (state == ntm_scalar_ctrl_pkg::EXP_MULTIPLY) ? DATA_A_IN : result;
  assign next_bit_state = (bit_count == '0) ? ntm_scalar_ctrl_pkg::EXP_DONE
                                            : ntm_scalar_ctrl_pkg::EXP_SQUARE;

  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) multiplier_inst (
    .CLK(CLK),
    .RST(RST),
    .START(mul_start),
    .READY(mul_ready),
    .MODULO_IN(MODULO_IN),
    .DATA_A_IN(result),
    .DATA_B_IN(mul_b),
    .DATA_OUT(mul_out)
  );

  ////////////////////////////////////////
  // Square-and-multiply FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_scalar_ctrl_pkg::EXP_IDLE;
      bit_count <= '0;
      exponent  <= '0;
      result    <= '0;
      started   <= 1'b0;
      waiting   <= 1'b0;
      mul_start <= 1'b0;
      READY     <= 1'b0;
      DATA_OUT  <= '0;
    end else begin
      READY     <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        ntm_scalar_ctrl_pkg::EXP_IDLE: begin
          if (START) begin
            exponent  <= DATA_B_IN;
            bit_count <= CNT_W'(DATA_SIZE - 1);
            // 1 mod M, zero when M is one
            result    <= (MODULO_IN == DATA_SIZE'(1)) ? '0 : DATA_SIZE'(1);
            started   <= 1'b0;
            waiting   <= 1'b0;
            state     <= ntm_scalar_ctrl_pkg::EXP_SQUARE;
          end
        end
        ntm_scalar_ctrl_pkg::EXP_SQUARE: begin
          if (!started) begin
            // Leading zeros cost one cycle each, nothing to square yet
            if (exponent[DATA_SIZE-1]) begin
              started <= 1'b1;
              state   <= ntm_scalar_ctrl_pkg::EXP_MULTIPLY;
            end else begin
              exponent  <= exponent << 1;
              bit_count <= bit_count - 1'b1;
              state     <= next_bit_state;
            end
          end else if (!waiting) begin
            mul_start <= 1'b1;
            waiting   <= 1'b1;
          end else if (mul_ready) begin
            result  <= mul_out;
            waiting <= 1'b0;
            if (exponent[DATA_SIZE-1]) begin
              state <= ntm_scalar_ctrl_pkg::EXP_MULTIPLY;
            end else begin
              exponent  <= exponent << 1;
              bit_count <= bit_count - 1'b1;
              state     <= next_bit_state;
            end
          end
        end
        ntm_scalar_ctrl_pkg::EXP_MULTIPLY: begin
          if (!waiting) begin
            mul_start <= 1'b1;
            waiting   <= 1'b1;
          end else if (mul_ready) begin
            result    <= mul_out;
            waiting   <= 1'b0;
            exponent  <= exponent << 1;
            bit_count <= bit_count - 1'b1;
            state     <= next_bit_state;
          end
        end
        ntm_scalar_ctrl_pkg::EXP_DONE: begin
          READY    <= 1'b1;
          DATA_OUT <= result;
          state    <= ntm_scalar_ctrl_pkg::EXP_IDLE;
        end
        default: state <= ntm_scalar_ctrl_pkg::EXP_IDLE;
      endcase
    end
  end

  // No second multiplication until the first one has reported
  assert property (@(posedge CLK) disable iff (RST)
    mul_start |=> (!mul_start throughout mul_ready [->1]));

endmodule

/* hw/ntm_scalar_result.sv */
// Output side of the scalar unit, captures the finishing engine or a refusal
// Registers DATA_OUT and STATUS and pulses READY for one cycle
`timescale 1ns/1ns

module ntm_scalar_result #(
  parameter int DATA_SIZE = 16
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          MUL_READY,
  input  logic [DATA_SIZE-1:0]          MUL_DATA,
  input  logic                          EXP_READY,
  input  logic [DATA_SIZE-1:0]          EXP_DATA,
  input  logic                          REFUSE,
  output logic                          READY,
  output ntm_scalar_ctrl_pkg::status_t  STATUS,
  output logic [DATA_SIZE-1:0]          DATA_OUT
);

  // Values hold until the next finish
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY    <= 1'b0;
      STATUS   <= '0;
      DATA_OUT <= '0;
    end else begin
      READY <= 1'b0;
      if (REFUSE) begin
        // Zero modulus, no engine ran
        READY    <= 1'b1;
        DATA_OUT <= '0;
        STATUS   <= '{done: 1'b1, error_code: ntm_scalar_op_pkg::ERR_ZERO_MODULUS};
      end else if (MUL_READY) begin
        READY    <= 1'b1;
        DATA_OUT <= MUL_DATA;
        STATUS   <= '{done: 1'b1, error_code: ntm_scalar_op_pkg::ERR_NONE};
      end else if (EXP_READY) begin
        READY    <= 1'b1;
        DATA_OUT <= EXP_DATA;
        STATUS   <= '{done: 1'b1, error_code: ntm_scalar_op_pkg::ERR_NONE};
      end
    end
  end

  // Only one command is ever in flight
  assert property (@(posedge CLK) disable iff (RST)
    $onehot0({MUL_READY, EXP_READY, REFUSE}));

endmodule

/* hw/ntm_scalar_unit.sv */
// Scalar modular arithmetic unit, MUL and EXP under one START/READY pair
// Input side, two engines and output side, DATA_SIZE set here for all
`timescale 1ns/1ns

module ntm_scalar_unit #(
  parameter int DATA_SIZE = 16
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          START,
  input  ntm_scalar_op_pkg::opcode_t    OPCODE,
  input  logic [DATA_SIZE-1:0]          MODULO_IN,
  input  logic [DATA_SIZE-1:0]          DATA_A_IN,
  input  logic [DATA_SIZE-1:0]          DATA_B_IN,
  output logic                          READY,
  output ntm_scalar_ctrl_pkg::status_t  STATUS,
  output logic [DATA_SIZE-1:0]          DATA_OUT,
  output logic                          BUSY
);

  ntm_scalar_op_pkg::command_t command;
  logic                 refuse;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] data_a;
  logic [DATA_SIZE-1:0] data_b;
  logic                 mul_start;
  logic                 mul_ready;
  logic [DATA_SIZE-1:0] mul_data;
  logic                 exp_start;
  logic                 exp_ready;
  logic [DATA_SIZE-1:0] exp_data;

  // Opcode steers the start pulse
  assign mul_start = command.start && (command.opcode == ntm_scalar_op_pkg::OP_MUL);
  assign exp_start = command.start && (command.opcode == ntm_scalar_op_pkg::OP_EXP);

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  ntm_scalar_command #(
    .DATA_SIZE(DATA_SIZE)
  ) command_inst (
    .CLK(CLK),
    .RST(RST),
    .START(START),
    .OPCODE(OPCODE),
    .MODULO_IN(MODULO_IN),
    .DATA_A_IN(DATA_A_IN),
    .DATA_B_IN(DATA_B_IN),
    .RESULT_READY(READY),
    .BUSY(BUSY),
    .COMMAND(command),
    .REFUSE(refuse),
    .MODULO_OUT(modulo),
    .DATA_A_OUT(data_a),
    .DATA_B_OUT(data_b)
  );

  ////////////////////////////////////////
  // Engines
  ////////////////////////////////////////

  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) multiplier_inst (
    .CLK(CLK),
    .RST(RST),
    .START(mul_start),
    .READY(mul_ready),
    .MODULO_IN(modulo),
    .DATA_A_IN(data_a),
    .DATA_B_IN(data_b),
    .DATA_OUT(mul_data)
  );

  ntm_scalar_exponentiator #(
    .DATA_SIZE(DATA_SIZE)
  ) exponentiator_inst (
    .CLK(CLK),
    .RST(RST),
    .START(exp_start),
    .READY(exp_ready),
    .MODULO_IN(modulo),
    .DATA_A_IN(data_a),
    .DATA_B_IN(data_b),
    .DATA_OUT(exp_data)
  );

  // Output side
  ntm_scalar_result #(
    .DATA_SIZE(DATA_SIZE)
  ) result_inst (
    .CLK(CLK),
    .RST(RST),
    .MUL_READY(mul_ready),
    .MUL_DATA(mul_data),
    .EXP_READY(exp_ready),
    .EXP_DATA(exp_data),
    .REFUSE(refuse),
    .READY(READY),
    .STATUS(STATUS),
    .DATA_OUT(DATA_OUT)
  );

endmodule

/* bench/ntm_scalar_clock.sv */
// Testbench clock and reset source for the scalar unit
// Reset is released on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ns

module ntm_scalar_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Reset held from time zero
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

/* bench/ntm_scalar_unit_tb.sv */
// Random-stimulus testbench for the scalar modular unit, MUL and EXP checked
// against a 64-bit model, zero modulus, START while busy and MUL latency
`timescale 1ns/1ns

module ntm_scalar_unit_tb;

  localparam int DATA_SIZE = 16;
  localparam int SEED      = 61787;
  localparam int N_MUL     = 40;
  localparam int N_EXP     = 30;
  // Latency, edge, zero modulus and busy cases
  localparam int N_TESTS   = N_MUL + N_EXP + 10;
  localparam longint unsigned MAX_M = (64'd1 << DATA_SIZE) - 1;
  // Two multiplications per exponent bit, each about DATA_SIZE+4 cycles
  localparam int READY_LIMIT = 2 * DATA_SIZE * (DATA_SIZE + 4) + 16;
  localparam longint WATCHDOG_NS = longint'(N_TESTS) * READY_LIMIT * 8 + 5000;

  logic clk;
  logic rst;
  logic start;
  ntm_scalar_op_pkg::opcode_t   opcode;
  logic [DATA_SIZE-1:0]         modulo;
  logic [DATA_SIZE-1:0]         data_a;
  logic [DATA_SIZE-1:0]         data_b;
  logic                         ready;
  ntm_scalar_ctrl_pkg::status_t status;
  logic [DATA_SIZE-1:0]         data_out;
  logic                         busy;

  int check_errors = 0;
  int test_count   = 0;
  int pass_count   = 0;
  int fail_count   = 0;

  ntm_scalar_clock #(.PERIOD(8), .RESET_CYCLES(8)) clock_inst (.CLK(clk), .RST(rst));

  ntm_scalar_unit #(
    .DATA_SIZE(DATA_SIZE)
  ) ntm_scalar_unit_inst (
    .CLK(clk),
    .RST(rst),
    .START(start),
    .OPCODE(opcode),
    .MODULO_IN(modulo),
    .DATA_A_IN(data_a),
    .DATA_B_IN(data_b),
    .READY(ready),
    .STATUS(status),
    .DATA_OUT(data_out),
    .BUSY(busy)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic longint unsigned model_mul(longint unsigned a, b, m);
    return (a * b) % m;
  endfunction

  // Left to right over all exponent bits, starting from 1 mod M
  function automatic longint unsigned model_exp(longint unsigned a, b, m);
    longint unsigned r;
    r = 1 % m;
    for (int i = DATA_SIZE - 1; i >= 0; i--) begin
      r = (r * r) % m;
      if (b[i]) r = (r * a) % m;
    end
    return r;
  endfunction

  // Nonzero modulus up to the full width
  function automatic longint unsigned rand_modulus();
    return (longint'($urandom) % MAX_M) + 1;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input logic [DATA_SIZE-1:0] got, expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
      check_errors++;
    end
  endtask

  task automatic check_status(input string name, input ntm_scalar_ctrl_pkg::status_t got,
                              input ntm_scalar_ctrl_pkg::status_t expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, expected);
      check_errors++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // START high for one cycle, returns on the falling edge that lowers it
  task automatic send_command(input ntm_scalar_op_pkg::opcode_t op,
                              input longint unsigned m, a, b);
    @(negedge clk);
    opcode = op;
    modulo = DATA_SIZE'(m);
    data_a = DATA_SIZE'(a);
    data_b = DATA_SIZE'(b);
    start  = 1'b1;
    @(negedge clk);
    start  = 1'b0;
  endtask

  // Counts falling edges from the one that raised START
  task automatic wait_for_ready(output int cycles, output bit seen);
    cycles = 1;
    seen   = 1'b0;
    while (!seen && cycles < READY_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (ready) seen = 1'b1;
    end
  endtask

  // BUSY still high with READY, low one cycle later
  task automatic wait_until_idle();
    if (!busy) begin
      $display("Error at %0t: BUSY low while READY is high", $time);
      check_errors++;
    end
    @(negedge clk);
    if (busy) begin
      $display("Error at %0t: BUSY stayed high after READY", $time);
      check_errors++;
    end
  endtask

  task automatic finish_test(input string label, input int errors_before);
    test_count++;
    if (check_errors == errors_before) begin
      pass_count++;
      $display("test %0d %s: ok", test_count, label);
    end else begin
      fail_count++;
      $display("test %0d %s: FAILED", test_count, label);
    end
  endtask

  // One command, checked against data, status and an optional latency
  task automatic run_case(input string label, input ntm_scalar_op_pkg::opcode_t op,
                          input longint unsigned m, a, b,
                          input logic [DATA_SIZE-1:0] expected,
                          input ntm_scalar_op_pkg::error_t err, input int exp_cycles);
    int cycles;
    bit seen;
    int errors_before;
    ntm_scalar_ctrl_pkg::status_t exp_status;
    errors_before = check_errors;
    exp_status.done = 1'b1;
    exp_status.error_code = err;
    send_command(op, m, a, b);
    wait_for_ready(cycles, seen);
    if (!seen) begin
      $display("Error at %0t: no READY within %0d cycles", $time, READY_LIMIT);
      check_errors++;
    end else begin
      check_data("DATA_OUT", data_out, expected);
      check_status("STATUS", status, exp_status);
      if (exp_cycles != 0 && cycles != exp_cycles) begin
        $display("Error at %0t: READY after %0d cycles, expected %0d", $time, cycles,
                 exp_cycles);
        check_errors++;
      end
    end
    wait_until_idle();
    finish_test($sformatf("%s %s", label, op.name()), errors_before);
  endtask

  // Second START while busy must be dropped
  task automatic busy_case(input longint unsigned m, a, b);
    int cycles;
    int extra;
    bit seen;
    int errors_before;
    errors_before = check_errors;
    send_command(ntm_scalar_op_pkg::OP_MUL, m, a, b);
    @(negedge clk);
    if (!busy) begin
      $display("Error at %0t: BUSY low while the first command runs", $time);
      check_errors++;
    end
    opcode = ntm_scalar_op_pkg::OP_EXP;
    data_b = DATA_SIZE'(b + 1);
    start  = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    wait_for_ready(cycles, seen);
    if (!seen) begin
      $display("Error at %0t: no READY for the first command", $time);
      check_errors++;
    end else begin
      check_data("DATA_OUT", data_out, DATA_SIZE'(model_mul(a, b, m)));
    end
    // Watch long enough for a stray second result
    extra = 0;
    repeat (READY_LIMIT) begin
      @(negedge clk);
      if (ready) extra++;
    end
    if (extra != 0) begin
      $display("Error at %0t: %0d extra READY pulses after one command", $time, extra);
      check_errors++;
    end
    finish_test("start while busy", errors_before);
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    longint unsigned m;
    longint unsigned a;
    longint unsigned b;
    int unsigned seed_value;
    start  = 1'b0;
    opcode = ntm_scalar_op_pkg::OP_MUL;
    modulo = '0;
    data_a = '0;
    data_b = '0;
    seed_value = $urandom(SEED);
    @(negedge rst);
    repeat (2) @(negedge clk);

    // Fixed MUL latency from START to READY
    m = rand_modulus();
    a = longint'($urandom) % m;
    b = longint'($urandom) % m;
    run_case("latency", ntm_scalar_op_pkg::OP_MUL, m, a, b, DATA_SIZE'(model_mul(a, b, m)),
             ntm_scalar_op_pkg::ERR_NONE, DATA_SIZE + 4);

    for (int i = 0; i < N_MUL; i++) begin
      m = rand_modulus();
      a = longint'($urandom) % m;
      b = longint'($urandom) % m;
      run_case("random", ntm_scalar_op_pkg::OP_MUL, m, a, b, DATA_SIZE'(model_mul(a, b, m)),
               ntm_scalar_op_pkg::ERR_NONE, 0);
    end

    // Exponent takes any value
    for (int i = 0; i < N_EXP; i++) begin
      m = rand_modulus();
      a = longint'($urandom) % m;
      b = longint'($urandom) & MAX_M;
      run_case("random", ntm_scalar_op_pkg::OP_EXP, m, a, b, DATA_SIZE'(model_exp(a, b, m)),
               ntm_scalar_op_pkg::ERR_NONE, 0);
    end

    // Edge values
    m = rand_modulus();
    a = longint'($urandom) % m;
    run_case("zero exponent", ntm_scalar_op_pkg::OP_EXP, m, a, 0, DATA_SIZE'(1 % m),
             ntm_scalar_op_pkg::ERR_NONE, 0);
    run_case("modulus one", ntm_scalar_op_pkg::OP_MUL, 1, 0, 0, '0,
             ntm_scalar_op_pkg::ERR_NONE, 0);
    // 0^0 mod 1, the starting power itself must already be reduced
    run_case("modulus one", ntm_scalar_op_pkg::OP_EXP, 1, 0, 0, '0,
             ntm_scalar_op_pkg::ERR_NONE, 0);
    run_case("largest modulus", ntm_scalar_op_pkg::OP_MUL, MAX_M, MAX_M - 1, MAX_M - 1,
             DATA_SIZE'(model_mul(MAX_M - 1, MAX_M - 1, MAX_M)), ntm_scalar_op_pkg::ERR_NONE, 0);
    run_case("largest modulus", ntm_scalar_op_pkg::OP_EXP, MAX_M, MAX_M - 1, MAX_M - 1,
             DATA_SIZE'(model_exp(MAX_M - 1, MAX_M - 1, MAX_M)), ntm_scalar_op_pkg::ERR_NONE, 0);

    // Zero modulus refused on both opcodes, READY two cycles later
    run_case("zero modulus", ntm_scalar_op_pkg::OP_MUL, 0, 5, 7, '0,
             ntm_scalar_op_pkg::ERR_ZERO_MODULUS, 2);
    run_case("zero modulus", ntm_scalar_op_pkg::OP_EXP, 0, 3, 9, '0,
             ntm_scalar_op_pkg::ERR_ZERO_MODULUS, 2);

    m = rand_modulus();
    busy_case(m, longint'($urandom) % m, longint'($urandom) % m);

    $display("Tests run: %0d, passed: %0d, failed: %0d", test_count, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
hw/ntm_scalar_op_pkg.sv
hw/ntm_scalar_ctrl_pkg.sv
hw/ntm_scalar_command.sv
hw/ntm_scalar_multiplier.sv
hw/ntm_scalar_exponentiator.sv
hw/ntm_scalar_result.sv
hw/ntm_scalar_unit.sv
bench/ntm_scalar_clock.sv
bench/ntm_scalar_unit_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the scalar unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_scalar_unit_tb \
  -Mdir obj_dir \
  -f src.f

./obj_dir/Vntm_scalar_unit_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
